// ==== bench/host_mem_properties.sv ====
// valid/ready rules on the pcim ports; not checked while sync_rst_n is low
`timescale 1ns/1ns
module host_mem_properties #(
   parameter int NUM_LANES = 4
) (
   input logic                                     clk_core,
   input logic                                     sync_rst_n,
   input logic                                     awready_i,
   input logic                                     wready_i,
   input host_mem_pkg::pcim_bresp_s                b_i,
   input logic                                     bvalid_i,
   input logic                                     bready_i,
   input logic                                     arready_i,
   input host_mem_pkg::lane_data_t [NUM_LANES-1:0] rdata_i,
   input logic                                     rlast_i,
   input logic                                     rvalid_i,
   input logic                                     rready_i
);
   a_b_hold: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      bvalid_i && !bready_i |=> bvalid_i && $stable(b_i))
      else $error("bvalid dropped or the response changed while bready was low");

   a_r_hold: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rlast_i))
      else $error("r beat changed while rready was low");

   a_aw_w_apart: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      !(awready_i && wready_i))
      else $error("awready and wready high together");

   a_ar_r_apart: assert property (@(posedge clk_core) disable iff (!sync_rst_n)
      !(arready_i && rvalid_i))
      else $error("arready and rvalid high together");

endmodule

bind host_mem_model host_mem_properties #(
   .NUM_LANES (NUM_LANES)
) u_props (
   .clk_core   (clk_core),
   .sync_rst_n (sync_rst_n),
   .awready_i  (pcim_awready_o),
   .wready_i   (pcim_wready_o),
   .b_i        (pcim_b_o),
   .bvalid_i   (pcim_bvalid_o),
   .bready_i   (pcim_bready_i),
   .arready_i  (pcim_arready_o),
   .rdata_i    (pcim_rdata_o),
   .rlast_i    (pcim_rlast_o),
   .rvalid_i   (pcim_rvalid_o),
   .rready_i   (pcim_rready_i)
);

// ==== bench/host_mem_tb.sv ====
// default parameters only (4 lanes, 64 beats); addresses are driven beat-aligned
`timescale 1ns/1ns
module host_mem_tb;
   localparam int NUM_LANES      = 4;
   localparam int BEAT_ADDR_W    = 6;
   localparam int DEPTH          = 2 ** BEAT_ADDR_W;
   localparam int BEAT_BYTES     = 4 * NUM_LANES;
   localparam int TIMEOUT_CYCLES = 3000;  // all tests take well under 1000

   typedef logic [8*BEAT_BYTES-1:0] beat_t;
   typedef logic [BEAT_BYTES-1:0]   strb_t;

   logic                                     clk_core;
   logic                                     sync_rst_n;
   host_mem_pkg::pcim_cmd_s                  pcim_aw;
   logic                                     pcim_awvalid;
   logic                                     pcim_awready;
   host_mem_pkg::lane_data_t [NUM_LANES-1:0] pcim_wdata;
   host_mem_pkg::lane_strb_t [NUM_LANES-1:0] pcim_wstrb;
   logic                                     pcim_wlast;
   logic                                     pcim_wvalid;
   logic                                     pcim_wready;
   host_mem_pkg::pcim_bresp_s                pcim_b;
   logic                                     pcim_bvalid;
   logic                                     pcim_bready;
   host_mem_pkg::pcim_cmd_s                  pcim_ar;
   logic                                     pcim_arvalid;
   logic                                     pcim_arready;
   host_mem_pkg::pcim_id_t                   pcim_rid;
   host_mem_pkg::lane_data_t [NUM_LANES-1:0] pcim_rdata;
   host_mem_pkg::pcim_resp_t                 pcim_rresp;
   logic                                     pcim_rlast;
   logic                                     pcim_rvalid;
   logic                                     pcim_rready;

   beat_t shadow [DEPTH];  // expected memory contents
   beat_t burst_data [16];
   strb_t burst_strb [16];
   int    err_cnt;
   int    check_cnt;
   int    cycle_cnt;

   host_mem_model u_dut (.*, .pcim_aw_i(pcim_aw), .pcim_awvalid_i(pcim_awvalid),
      .pcim_awready_o(pcim_awready), .pcim_wdata_i(pcim_wdata), .pcim_wstrb_i(pcim_wstrb),
      .pcim_wlast_i(pcim_wlast), .pcim_wvalid_i(pcim_wvalid), .pcim_wready_o(pcim_wready),
      .pcim_b_o(pcim_b), .pcim_bvalid_o(pcim_bvalid), .pcim_bready_i(pcim_bready),
      .pcim_ar_i(pcim_ar), .pcim_arvalid_i(pcim_arvalid), .pcim_arready_o(pcim_arready),
      .pcim_rid_o(pcim_rid), .pcim_rdata_o(pcim_rdata), .pcim_rresp_o(pcim_rresp),
      .pcim_rlast_o(pcim_rlast), .pcim_rvalid_o(pcim_rvalid), .pcim_rready_i(pcim_rready));

   initial clk_core = 1'b0;
   always #5 clk_core = ~clk_core;

   always @(posedge clk_core) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // --------------------
   // helpers
   // --------------------
   task automatic step();
      @(posedge clk_core);
      #1;  // drive and sample 1 ns after the edge
   endtask

   task automatic check(input string name, input beat_t expected, input beat_t actual);
      check_cnt++;
      if (actual !== expected) begin
         err_cnt++;
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // strobed bytes replace the old ones
   function automatic beat_t merge_beat(input beat_t old_beat, input beat_t data,
                                        input strb_t strb);
      beat_t result;
      result = old_beat;
      for (int b = 0; b < BEAT_BYTES; b++) begin
         if (strb[b]) result[8*b +: 8] = data[8*b +: 8];
      end
      return result;
   endfunction

   task automatic write_burst(input string name, input host_mem_pkg::pcim_id_t id,
                              input int beat, input int nbeats, input bit stall);
      host_mem_pkg::pcim_bresp_s held_b;
      int                        idx;
      pcim_aw.id   = id;
      pcim_aw.addr = host_mem_pkg::pcim_addr_t'(beat * BEAT_BYTES);
      pcim_aw.len  = host_mem_pkg::pcim_len_t'(nbeats - 1);
      pcim_awvalid = 1'b1;
      while (!pcim_awready) step();
      step();
      pcim_awvalid = 1'b0;
      for (int i = 0; i < nbeats; i++) begin
         if (stall) repeat ($urandom_range(2, 0)) step();  // gap in wvalid
         pcim_wdata  = burst_data[i];
         pcim_wstrb  = burst_strb[i];
         pcim_wlast  = (i == nbeats - 1);
         pcim_wvalid = 1'b1;
         while (!pcim_wready) step();
         step();
         pcim_wvalid = 1'b0;
         pcim_wlast  = 1'b0;
         idx         = (beat + i) % DEPTH;
         shadow[idx] = merge_beat(shadow[idx], burst_data[i], burst_strb[i]);
      end
      check({name, " bvalid one cycle after wlast"}, beat_t'(1'b1), beat_t'(pcim_bvalid));
      held_b = pcim_b;
      if (stall) begin
         repeat ($urandom_range(4, 0)) begin
            step();
            check({name, " b held"}, beat_t'({1'b1, held_b}), beat_t'({pcim_bvalid, pcim_b}));
         end
      end
      pcim_bready = 1'b1;
      while (!pcim_bvalid) step();
      check({name, " bid"}, beat_t'(id), beat_t'(pcim_b.id));
      check({name, " bresp"}, beat_t'(2'b00), beat_t'(pcim_b.resp));
      step();
      pcim_bready = 1'b0;
      check({name, " awready after b"}, beat_t'(1'b1), beat_t'(pcim_awready));
   endtask

   task automatic read_burst(input string name, input host_mem_pkg::pcim_id_t id,
                             input int beat, input int nbeats, input bit stall);
      int                     lat;
      beat_t                  held_data;
      logic                   held_last;
      host_mem_pkg::pcim_id_t held_id;
      pcim_ar.id   = id;
      pcim_ar.addr = host_mem_pkg::pcim_addr_t'(beat * BEAT_BYTES);
      pcim_ar.len  = host_mem_pkg::pcim_len_t'(nbeats - 1);
      pcim_arvalid = 1'b1;
      while (!pcim_arready) step();
      step();
      pcim_arvalid = 1'b0;
      for (int i = 0; i < nbeats; i++) begin
         lat = 1;  // cycles since the handshake cycle
         while (!pcim_rvalid) begin
            step();
            lat++;
         end
         check({name, " rvalid latency"}, beat_t'(2), beat_t'(lat));
         held_data = pcim_rdata;
         held_last = pcim_rlast;
         held_id   = pcim_rid;
         if (stall) begin
            repeat ($urandom_range(4, 0)) begin
               step();
               check({name, " rdata held"}, held_data, pcim_rdata);
               check({name, " rid held"}, beat_t'(held_id), beat_t'(pcim_rid));
               check({name, " rvalid rlast held"}, beat_t'({1'b1, held_last}),
                     beat_t'({pcim_rvalid, pcim_rlast}));
            end
         end
         check({name, " rdata"}, shadow[(beat + i) % DEPTH], pcim_rdata);
         check({name, " rid"}, beat_t'(id), beat_t'(pcim_rid));
         check({name, " rresp"}, beat_t'(2'b00), beat_t'(pcim_rresp));
         check({name, " rlast"}, beat_t'(i == nbeats - 1), beat_t'(pcim_rlast));
         pcim_rready = 1'b1;
         step();
         pcim_rready = 1'b0;
      end
      check({name, " arready after last beat"}, beat_t'(1'b1), beat_t'(pcim_arready));
   endtask

   // --------------------
   // directed tests
   // --------------------
   task automatic test_reset_state();
      check("reset_state ready levels", beat_t'(2'b11), beat_t'({pcim_awready, pcim_arready}));
      check("reset_state valid levels", beat_t'(3'b000),
            beat_t'({pcim_wready, pcim_bvalid, pcim_rvalid}));
   endtask

   task automatic test_single_beat();
      burst_data[0] = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
      burst_strb[0] = '1;
      write_burst("single_beat", 5'd3, 5, 1, 1'b0);
      read_burst("single_beat", 5'd7, 5, 1, 1'b0);
   endtask

   task automatic test_partial_write();
      read_burst("partial_write unwritten", 5'd1, 20, 1, 1'b0);
      burst_data[0] = 128'h1111_2222_3333_4444_5555_6666_7777_8888;
      burst_strb[0] = 16'b0110_0000_1000_0011;
      write_burst("partial_write", 5'd2, 21, 1, 1'b0);
      read_burst("partial_write", 5'd4, 21, 1, 1'b0);
   endtask

   task automatic test_burst();
      for (int i = 0; i < 4; i++) begin
         burst_data[i] = {4{8'(i), 24'h5a_c3e1}};
         burst_strb[i] = '1;
      end
      write_burst("burst", 5'd9, 8, 4, 1'b0);
      read_burst("burst", 5'd10, 8, 4, 1'b0);
   endtask

   task automatic test_backpressure();
      int beat;
      int nbeats;
      repeat (6) begin
         beat   = int'($urandom_range(DEPTH - 1, 0));  // bursts may wrap past the top
         nbeats = int'($urandom_range(8, 1));
         for (int i = 0; i < nbeats; i++) begin
            burst_data[i] = {$urandom, $urandom, $urandom, $urandom};
            burst_strb[i] = strb_t'($urandom);
         end
         write_burst("backpressure", 5'($urandom), beat, nbeats, 1'b1);
         read_burst("backpressure", 5'($urandom), beat, nbeats, 1'b1);
      end
   endtask

   task automatic test_reset_clears();
      sync_rst_n = 1'b0;
      repeat (3) step();
      sync_rst_n = 1'b1;
      for (int i = 0; i < DEPTH; i++) shadow[i] = '1;
      read_burst("reset_clears", 5'd11, 5, 1, 1'b0);
      read_burst("reset_clears", 5'd12, 8, 4, 1'b0);
      read_burst("reset_clears", 5'd13, 21, 1, 1'b0);
   endtask

   initial begin
      void'($urandom(32'hb9d3a7b7));
      {pcim_awvalid, pcim_wvalid, pcim_wlast, pcim_bready} = '0;
      {pcim_arvalid, pcim_rready} = '0;
      pcim_aw    = '0;
      pcim_ar    = '0;
      pcim_wdata = '0;
      pcim_wstrb = '0;
      sync_rst_n = 1'b0;
      for (int i = 0; i < DEPTH; i++) shadow[i] = '1;
      repeat (3) step();
      sync_rst_n = 1'b1;
      test_reset_state();
      test_single_beat();
      test_partial_write();
      test_burst();
      test_backpressure();
      test_reset_clears();
      $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== hdl/host_mem_lane.sv ====
// one lane word per beat index; words never written since reset read back as all ones
`timescale 1ns/1ns
module host_mem_lane #(
   parameter int BEAT_ADDR_W = 6
) (
   input  logic                     clk_core,
   input  logic                     sync_rst_n,
   input  logic                     wr_en_i,
   input  logic [BEAT_ADDR_W-1:0]   wr_idx_i,
   input  host_mem_pkg::lane_data_t wr_data_i,
   input  host_mem_pkg::lane_strb_t wr_strb_i,
   input  logic                     rd_en_i,
   input  logic [BEAT_ADDR_W-1:0]   rd_idx_i,
   output host_mem_pkg::lane_data_t rd_data_o
);
   localparam int DEPTH = 2 ** BEAT_ADDR_W;

   host_mem_pkg::lane_data_t mem_q [DEPTH];
   logic [DEPTH-1:0]         written_q;   // one flag per word
   host_mem_pkg::lane_data_t old_word;
   host_mem_pkg::lane_data_t merged_word;

   // unwritten words merge into the all-ones default
   assign old_word = written_q[wr_idx_i] ? mem_q[wr_idx_i] : '1;

   always_comb begin
      for (int b = 0; b < host_mem_pkg::LANE_BYTES; b++) begin
         merged_word[8*b +: 8] = wr_strb_i[b] ? wr_data_i[8*b +: 8] : old_word[8*b +: 8];
      end
   end

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         written_q <= '0;
      end else if (wr_en_i) begin
         written_q[wr_idx_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk_core) begin
      if (wr_en_i) begin
         mem_q[wr_idx_i] <= merged_word;
      end
   end

   // same-edge write to this word is not seen here
   always_ff @(posedge clk_core) begin
      if (rd_en_i) begin
         rd_data_o <= written_q[rd_idx_i] ? mem_q[rd_idx_i] : '1;
      end
   end

endmodule

// ==== hdl/host_mem_model.sv ====
// host memory seen from the pcim master port; beat-aligned addresses, one burst per direction
`timescale 1ns/1ns
module host_mem_model #(
   parameter int NUM_LANES   = 4,
   parameter int BEAT_ADDR_W = 6
) (
   input  logic                                     clk_core,
   input  logic                                     sync_rst_n,
   // write side
   input  host_mem_pkg::pcim_cmd_s                  pcim_aw_i,
   input  logic                                     pcim_awvalid_i,
   output logic                                     pcim_awready_o,
   input  host_mem_pkg::lane_data_t [NUM_LANES-1:0] pcim_wdata_i,
   input  host_mem_pkg::lane_strb_t [NUM_LANES-1:0] pcim_wstrb_i,
   input  logic                                     pcim_wlast_i,
   input  logic                                     pcim_wvalid_i,
   output logic                                     pcim_wready_o,
   output host_mem_pkg::pcim_bresp_s                pcim_b_o,
   output logic                                     pcim_bvalid_o,
   input  logic                                     pcim_bready_i,
   // read side
   input  host_mem_pkg::pcim_cmd_s                  pcim_ar_i,
   input  logic                                     pcim_arvalid_i,
   output logic                                     pcim_arready_o,
   output host_mem_pkg::pcim_id_t                   pcim_rid_o,
   output host_mem_pkg::lane_data_t [NUM_LANES-1:0] pcim_rdata_o,
   output host_mem_pkg::pcim_resp_t                 pcim_rresp_o,
   output logic                                     pcim_rlast_o,
   output logic                                     pcim_rvalid_o,
   input  logic                                     pcim_rready_i
);
   logic                                     lane_wr_en;
   logic [BEAT_ADDR_W-1:0]                   lane_wr_idx;
   host_mem_pkg::lane_data_t [NUM_LANES-1:0] lane_wr_data;
   host_mem_pkg::lane_strb_t [NUM_LANES-1:0] lane_wr_strb;
   logic                                     lane_rd_en;
   logic [BEAT_ADDR_W-1:0]                   lane_rd_idx;
   host_mem_pkg::lane_data_t [NUM_LANES-1:0] lane_rd_data;

   pcim_write_ctrl #(
      .NUM_LANES   (NUM_LANES),
      .BEAT_ADDR_W (BEAT_ADDR_W)
   ) u_write_ctrl (
      .clk_core       (clk_core),
      .sync_rst_n     (sync_rst_n),
      .pcim_aw_i      (pcim_aw_i),
      .pcim_awvalid_i (pcim_awvalid_i),
      .pcim_awready_o (pcim_awready_o),
      .pcim_wdata_i   (pcim_wdata_i),
      .pcim_wstrb_i   (pcim_wstrb_i),
      .pcim_wlast_i   (pcim_wlast_i),
      .pcim_wvalid_i  (pcim_wvalid_i),
      .pcim_wready_o  (pcim_wready_o),
      .pcim_b_o       (pcim_b_o),
      .pcim_bvalid_o  (pcim_bvalid_o),
      .pcim_bready_i  (pcim_bready_i),
      .lane_wr_en_o   (lane_wr_en),
      .lane_wr_idx_o  (lane_wr_idx),
      .lane_wr_data_o (lane_wr_data),
      .lane_wr_strb_o (lane_wr_strb)
   );

   pcim_read_ctrl #(
      .NUM_LANES   (NUM_LANES),
      .BEAT_ADDR_W (BEAT_ADDR_W)
   ) u_read_ctrl (
      .clk_core       (clk_core),
      .sync_rst_n     (sync_rst_n),
      .pcim_ar_i      (pcim_ar_i),
      .pcim_arvalid_i (pcim_arvalid_i),
      .pcim_arready_o (pcim_arready_o),
      .pcim_rid_o     (pcim_rid_o),
      .pcim_rdata_o   (pcim_rdata_o),
      .pcim_rresp_o   (pcim_rresp_o),
      .pcim_rlast_o   (pcim_rlast_o),
      .pcim_rvalid_o  (pcim_rvalid_o),
      .pcim_rready_i  (pcim_rready_i),
      .lane_rd_en_o   (lane_rd_en),
      .lane_rd_idx_o  (lane_rd_idx),
      .lane_rd_data_i (lane_rd_data)
   );

   // --------------------
   // lanes, lane 0 holds the lowest bytes of a beat
   // --------------------
   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      host_mem_lane #(
         .BEAT_ADDR_W (BEAT_ADDR_W)
      ) u_lane (
         .clk_core   (clk_core),
         .sync_rst_n (sync_rst_n),
         .wr_en_i    (lane_wr_en),
         .wr_idx_i   (lane_wr_idx),
         .wr_data_i  (lane_wr_data[g]),
         .wr_strb_i  (lane_wr_strb[g]),
         .rd_en_i    (lane_rd_en),
         .rd_idx_i   (lane_rd_idx),
         .rd_data_o  (lane_rd_data[g])
      );
   end

endmodule

// ==== hdl/host_mem_pkg.sv ====
// byte addresses are 16 bits wide; bursts are at most 256 beats and no wrap or fixed modes exist
package host_mem_pkg;

   // --------------------
   // lane geometry
   // --------------------
   localparam int LANE_BYTES = 4;  // bytes per lane word

   typedef logic [8*LANE_BYTES-1:0] lane_data_t;
   typedef logic [LANE_BYTES-1:0]   lane_strb_t;

   // --------------------
   // channel fields
   // --------------------
   typedef logic [15:0] pcim_addr_t;  // byte address
   typedef logic [4:0]  pcim_id_t;
   typedef logic [7:0]  pcim_len_t;   // beats minus one
   typedef logic [1:0]  pcim_resp_t;

   localparam pcim_resp_t RESP_OKAY = 2'b00;  // only response ever sent

   // aw and ar commands share one layout
   typedef struct packed {
      pcim_id_t   id;
      pcim_addr_t addr;
      pcim_len_t  len;
   } pcim_cmd_s;

   // write response
   typedef struct packed {
      pcim_id_t   id;
      pcim_resp_t resp;
   } pcim_bresp_s;

endpackage

// ==== hdl/pcim_read_ctrl.sv ====
// one read burst at a time; every beat costs a lane fetch cycle, so rvalid drops between beats
`timescale 1ns/1ns
module pcim_read_ctrl #(
   parameter int NUM_LANES   = 4,
   parameter int BEAT_ADDR_W = 6
) (
   input  logic                                     clk_core,
   input  logic                                     sync_rst_n,
   input  host_mem_pkg::pcim_cmd_s                  pcim_ar_i,
   input  logic                                     pcim_arvalid_i,
   output logic                                     pcim_arready_o,
   output host_mem_pkg::pcim_id_t                   pcim_rid_o,
   output host_mem_pkg::lane_data_t [NUM_LANES-1:0] pcim_rdata_o,
   output host_mem_pkg::pcim_resp_t                 pcim_rresp_o,
   output logic                                     pcim_rlast_o,
   output logic                                     pcim_rvalid_o,
   input  logic                                     pcim_rready_i,
   output logic                                     lane_rd_en_o,
   output logic [BEAT_ADDR_W-1:0]                   lane_rd_idx_o,
   input  host_mem_pkg::lane_data_t [NUM_LANES-1:0] lane_rd_data_i
);
   localparam int OFF_W = $clog2(NUM_LANES * host_mem_pkg::LANE_BYTES);

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_FETCH,
      RD_BEAT
   } rd_state_e;

   rd_state_e               state_q;
   logic [BEAT_ADDR_W-1:0]  idx_q;
   host_mem_pkg::pcim_len_t cnt_q;   // beats left after the current one
   host_mem_pkg::pcim_id_t  id_q;
   logic                    ar_xfer;
   logic                    r_xfer;

   assign pcim_arready_o = (state_q == RD_IDLE);
   assign pcim_rvalid_o  = (state_q == RD_BEAT);

   assign ar_xfer = pcim_arvalid_i && pcim_arready_o;
   assign r_xfer  = pcim_rvalid_o && pcim_rready_i;

   // --------------------
   // burst sequencing
   // --------------------
   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q <= RD_IDLE;
         idx_q   <= '0;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (ar_xfer) begin
                  idx_q   <= pcim_ar_i.addr[OFF_W +: BEAT_ADDR_W];
                  cnt_q   <= pcim_ar_i.len;
                  state_q <= RD_FETCH;
               end
            end
            RD_FETCH: state_q <= RD_BEAT;  // lanes register the beat this edge
            RD_BEAT: begin
               if (r_xfer) begin
                  if (cnt_q == '0) begin
                     state_q <= RD_IDLE;
                  end else begin
                     idx_q   <= idx_q + 1'b1;
                     cnt_q   <= cnt_q - 1'b1;
                     state_q <= RD_FETCH;
                  end
               end
            end
            default: state_q <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_core) begin
      if (ar_xfer) begin
         id_q <= pcim_ar_i.id;
      end
   end

   // --------------------
   // lane read port and r channel
   // --------------------
   assign lane_rd_en_o  = (state_q == RD_FETCH);
   assign lane_rd_idx_o = idx_q;

   // lane outputs only change on a fetch, so the beat holds under back-pressure
   assign pcim_rdata_o = lane_rd_data_i;
   assign pcim_rid_o   = id_q;
   assign pcim_rresp_o = host_mem_pkg::RESP_OKAY;
   assign pcim_rlast_o = pcim_rvalid_o && (cnt_q == '0);

endmodule

// ==== hdl/pcim_write_ctrl.sv ====
// one write burst at a time; the burst ends on wlast and awlen is not compared with the beat count
`timescale 1ns/1ns
module pcim_write_ctrl #(
   parameter int NUM_LANES   = 4,
   parameter int BEAT_ADDR_W = 6
) (
   input  logic                                     clk_core,
   input  logic                                     sync_rst_n,
   input  host_mem_pkg::pcim_cmd_s                  pcim_aw_i,
   input  logic                                     pcim_awvalid_i,
   output logic                                     pcim_awready_o,
   input  host_mem_pkg::lane_data_t [NUM_LANES-1:0] pcim_wdata_i,
   input  host_mem_pkg::lane_strb_t [NUM_LANES-1:0] pcim_wstrb_i,
   input  logic                                     pcim_wlast_i,
   input  logic                                     pcim_wvalid_i,
   output logic                                     pcim_wready_o,
   output host_mem_pkg::pcim_bresp_s                pcim_b_o,
   output logic                                     pcim_bvalid_o,
   input  logic                                     pcim_bready_i,
   output logic                                     lane_wr_en_o,
   output logic [BEAT_ADDR_W-1:0]                   lane_wr_idx_o,
   output host_mem_pkg::lane_data_t [NUM_LANES-1:0] lane_wr_data_o,
   output host_mem_pkg::lane_strb_t [NUM_LANES-1:0] lane_wr_strb_o
);
   // byte offset bits inside one beat
   localparam int OFF_W = $clog2(NUM_LANES * host_mem_pkg::LANE_BYTES);

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   wr_state_e              state_q;
   logic [BEAT_ADDR_W-1:0] idx_q;
   host_mem_pkg::pcim_id_t id_q;
   logic                   aw_xfer;
   logic                   w_xfer;
   logic                   b_xfer;

   // --------------------
   // handshakes
   // --------------------
   assign pcim_awready_o = (state_q == WR_IDLE);
   assign pcim_wready_o  = (state_q == WR_DATA);
   assign pcim_bvalid_o  = (state_q == WR_RESP);

   assign aw_xfer = pcim_awvalid_i && pcim_awready_o;
   assign w_xfer  = pcim_wvalid_i && pcim_wready_o;
   assign b_xfer  = pcim_bvalid_o && pcim_bready_i;

   always_ff @(posedge clk_core or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q <= WR_IDLE;
         idx_q   <= '0;
      end else begin
         case (state_q)
            WR_IDLE: begin
               if (aw_xfer) begin
                  idx_q   <= pcim_aw_i.addr[OFF_W +: BEAT_ADDR_W];  // upper bits wrap
                  state_q <= WR_DATA;
               end
            end
            WR_DATA: begin
               if (w_xfer) begin
                  idx_q <= idx_q + 1'b1;
                  if (pcim_wlast_i) state_q <= WR_RESP;
               end
            end
            WR_RESP: begin
               if (b_xfer) state_q <= WR_IDLE;
            end
            default: state_q <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_core) begin
      if (aw_xfer) begin
         id_q <= pcim_aw_i.id;
      end
   end

   always_comb begin
      pcim_b_o.id   = id_q;
      pcim_b_o.resp = host_mem_pkg::RESP_OKAY;
   end

   // --------------------
   // lane write port
   // --------------------
   assign lane_wr_en_o   = w_xfer;  // beat lands at the w transfer edge
   assign lane_wr_idx_o  = idx_q;
   assign lane_wr_data_o = pcim_wdata_i;
   assign lane_wr_strb_o = pcim_wstrb_i;

endmodule

// ==== project.f ====
hdl/host_mem_pkg.sv
hdl/host_mem_lane.sv
hdl/pcim_write_ctrl.sv
hdl/pcim_read_ctrl.sv
hdl/host_mem_model.sv
bench/host_mem_properties.sv
bench/host_mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds host_mem_tb with Verilator, runs it and judges the run from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module host_mem_tb -f project.f \
   -o host_mem_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/host_mem_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
